//--- Bender.yml
package:
  name: axi_burst_mem

sources:
  - include_dirs:
      - logic
    files:
      - logic/axi_burst_pkg.sv
      - logic/burst_addr_gen.sv
      - logic/write_channel.sv
      - logic/read_channel.sv
      - logic/burst_ram.sv
      - logic/axi_burst_mem.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/tb_axi_burst_mem.sv

//--- axi_burst_mem.f
+incdir+logic
logic/axi_burst_pkg.sv
logic/burst_addr_gen.sv
logic/write_channel.sv
logic/read_channel.sv
logic/burst_ram.sv
logic/axi_burst_mem.sv
verif/tb_axi_burst_mem.sv

//--- logic/axi_burst_defines.svh
`ifndef AXI_BURST_DEFINES_SVH
`define AXI_BURST_DEFINES_SVH

// beat width in bits
`define AXI_DATA_W 32

// byte address width
`define AXI_ADDR_W 12

// one strobe bit per data byte
`define AXI_STRB_W (`AXI_DATA_W / 8)

// buffer RAM geometry
`define RAM_DEPTH 32
`define RAM_IDX_W 5

// byte lanes inside one word
`define BYTE_OFS_W 2

`endif

//--- logic/axi_burst_mem.sv
`timescale 1ns/1ps
`include "axi_burst_defines.svh"

module axi_burst_mem (
  input  logic                         S_AXI_ACLK,
  input  logic                         S_AXI_ARESETN,
  input  axi_burst_pkg::axi_addr_req_t i_s_axi_aw,
  input  logic                         i_s_axi_awvalid,
  output logic                         o_s_axi_awready,
  input  axi_burst_pkg::w_beat_t       i_s_axi_w,
  input  logic                         i_s_axi_wvalid,
  output logic                         o_s_axi_wready,
  output axi_burst_pkg::axi_resp_e     o_s_axi_bresp,
  output logic                         o_s_axi_bvalid,
  input  logic                         i_s_axi_bready,
  input  axi_burst_pkg::axi_addr_req_t i_s_axi_ar,
  input  logic                         i_s_axi_arvalid,
  output logic                         o_s_axi_arready,
  output axi_burst_pkg::r_beat_t       o_s_axi_r,
  output logic                         o_s_axi_rvalid,
  input  logic                         i_s_axi_rready
);
  // busy flags keep the two channels mutually exclusive
  logic                   wr_busy;
  logic                   rd_busy;
  axi_burst_pkg::ram_wr_t ram_wr;
  logic [`RAM_IDX_W-1:0]  rd_idx;
  logic [`AXI_DATA_W-1:0] rd_data;

  write_channel u_write (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .i_aw          (i_s_axi_aw),
    .i_awvalid     (i_s_axi_awvalid),
    .o_awready     (o_s_axi_awready),
    .i_w           (i_s_axi_w),
    .i_wvalid      (i_s_axi_wvalid),
    .o_wready      (o_s_axi_wready),
    .o_bresp       (o_s_axi_bresp),
    .o_bvalid      (o_s_axi_bvalid),
    .i_bready      (i_s_axi_bready),
    .i_rd_busy     (rd_busy),
    .o_wr_busy     (wr_busy),
    .o_ram_wr      (ram_wr)
  );

  read_channel u_read (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .i_ar          (i_s_axi_ar),
    .i_arvalid     (i_s_axi_arvalid),
    .o_arready     (o_s_axi_arready),
    .i_awvalid     (i_s_axi_awvalid),
    .i_wr_busy     (wr_busy),
    .o_rd_busy     (rd_busy),
    .o_rd_idx      (rd_idx),
    .i_rd_data     (rd_data),
    .o_r           (o_s_axi_r),
    .o_rvalid      (o_s_axi_rvalid),
    .i_rready      (i_s_axi_rready)
  );

  burst_ram u_ram (
    .S_AXI_ACLK (S_AXI_ACLK),
    .i_wr       (ram_wr),
    .i_rd_idx   (rd_idx),
    .o_rd_data  (rd_data)
  );

endmodule

//--- logic/axi_burst_pkg.sv
`include "axi_burst_defines.svh"

package axi_burst_pkg;

  // AxBURST encodings
  typedef enum logic [1:0] {
    FIXED    = 2'b00,
    INCR     = 2'b01,
    WRAP     = 2'b10,
    RESERVED = 2'b11
  } axi_burst_e;

  // only the two codes this slave ever returns
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // address bits above the RAM index are don't-care
  typedef struct packed {
    logic [`AXI_ADDR_W-`RAM_IDX_W-`BYTE_OFS_W-1:0] tag;
    logic [`RAM_IDX_W-1:0]                         idx;
    logic [`BYTE_OFS_W-1:0]                        ofs;
  } axi_addr_fields_t;

  // byte view for burst arithmetic, field view for the RAM
  typedef union packed {
    logic [`AXI_ADDR_W-1:0] byte_addr;
    axi_addr_fields_t       field;
  } axi_addr_u;

  // shared by AW and AR
  typedef struct packed {
    axi_addr_u  addr;
    logic [7:0] len;
    axi_burst_e burst;
  } axi_addr_req_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
    logic                   last;
  } w_beat_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    axi_resp_e              resp;
    logic                   last;
  } r_beat_t;

  typedef struct packed {
    logic                   en;
    logic [`RAM_IDX_W-1:0]  idx;
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
  } ram_wr_t;

endpackage

//--- logic/burst_addr_gen.sv
`timescale 1ns/1ps
`include "axi_burst_defines.svh"

module burst_addr_gen (
  input  logic                         S_AXI_ACLK,
  input  logic                         S_AXI_ARESETN,
  input  logic                         i_load,
  input  axi_burst_pkg::axi_addr_req_t i_req,
  input  logic                         i_advance,
  output axi_burst_pkg::axi_addr_u     o_addr,
  output logic                         o_last,
  output logic                         o_err
);
  localparam int WORD_W = `AXI_ADDR_W - `BYTE_OFS_W;

  axi_burst_pkg::axi_addr_u  cur_addr;
  axi_burst_pkg::axi_burst_e burst_q;
  logic [7:0]                len_q;
  logic [7:0]                beat_cnt;
  logic [WORD_W-1:0]         word_addr;
  logic [WORD_W-1:0]         word_inc;
  logic [WORD_W-1:0]         wrap_mask;
  logic [WORD_W-1:0]         word_next;
  logic                      wrap_len_ok;
  logic                      step_en;

  // word-granular address, byte offset dropped
  assign word_addr = cur_addr.byte_addr[`AXI_ADDR_W-1:`BYTE_OFS_W];
  assign word_inc  = word_addr + 1'b1;

  // window of len+1 words, valid only for power-of-two lengths
  assign wrap_mask   = WORD_W'(len_q);
  assign wrap_len_ok = (len_q == 8'd1) || (len_q == 8'd3) ||
                       (len_q == 8'd7) || (len_q == 8'd15);

  assign o_err = (burst_q == axi_burst_pkg::RESERVED) ||
                 ((burst_q == axi_burst_pkg::WRAP) && !wrap_len_ok);

  // fixed and error bursts stay on one address
  assign step_en = !o_err && (burst_q != axi_burst_pkg::FIXED);

  always_comb begin
    if (burst_q == axi_burst_pkg::WRAP) begin
      word_next = (word_addr & ~wrap_mask) | (word_inc & wrap_mask);
    end else begin
      word_next = word_inc;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      beat_cnt <= '0;
      len_q    <= '0;
      burst_q  <= axi_burst_pkg::FIXED;
    end else if (i_load) begin
      beat_cnt <= '0;
      len_q    <= i_req.len;
      burst_q  <= i_req.burst;
    end else if (i_advance) begin
      beat_cnt <= beat_cnt + 8'd1;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (i_load) begin
      cur_addr <= i_req.addr;
    end else if (i_advance && step_en) begin
      cur_addr.byte_addr <= {word_next, {`BYTE_OFS_W{1'b0}}};
    end
  end

  assign o_addr = cur_addr;
  assign o_last = (beat_cnt == len_q);

  // once the final beat has moved, nothing advances until the next burst
  a_no_advance_past_last: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (i_advance && o_last) |=> (!i_advance until i_load)
  ) else $error("burst advanced past its final beat");

endmodule

//--- logic/burst_ram.sv
`timescale 1ns/1ps
`include "axi_burst_defines.svh"

module burst_ram (
  input  logic                   S_AXI_ACLK,
  input  axi_burst_pkg::ram_wr_t i_wr,
  input  logic [`RAM_IDX_W-1:0]  i_rd_idx,
  output logic [`AXI_DATA_W-1:0] o_rd_data
);
  logic [`AXI_DATA_W-1:0] mem [`RAM_DEPTH];

  // byte lanes written independently under strobe
  always_ff @(posedge S_AXI_ACLK) begin
    if (i_wr.en) begin
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (i_wr.strb[b]) begin
          mem[i_wr.idx][8*b +: 8] <= i_wr.data[8*b +: 8];
        end
      end
    end
  end

  // registered read every cycle
  always_ff @(posedge S_AXI_ACLK) begin
    o_rd_data <= mem[i_rd_idx];
  end

endmodule

//--- logic/read_channel.sv
`timescale 1ns/1ps
`include "axi_burst_defines.svh"

module read_channel (
  input  logic                         S_AXI_ACLK,
  input  logic                         S_AXI_ARESETN,
  input  axi_burst_pkg::axi_addr_req_t i_ar,
  input  logic                         i_arvalid,
  output logic                         o_arready,
  input  logic                         i_awvalid,
  input  logic                         i_wr_busy,
  output logic                         o_rd_busy,
  output logic [`RAM_IDX_W-1:0]        o_rd_idx,
  input  logic [`AXI_DATA_W-1:0]       i_rd_data,
  output axi_burst_pkg::r_beat_t       o_r,
  output logic                         o_rvalid,
  input  logic                         i_rready
);
  axi_burst_pkg::axi_addr_u rd_addr;
  logic                     ar_hs;
  logic                     r_hs;
  logic                     fetch_q;
  logic                     beat_last;
  logic                     burst_err;

  assign ar_hs = o_arready && i_arvalid;
  assign r_hs  = o_rvalid && i_rready;

  burst_addr_gen u_addr_gen (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .i_load        (ar_hs),
    .i_req         (i_ar),
    .i_advance     (r_hs),
    .o_addr        (rd_addr),
    .o_last        (beat_last),
    .o_err         (burst_err)
  );

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      o_arready <= 1'b0;
      o_rd_busy <= 1'b0;
      o_rvalid  <= 1'b0;
      fetch_q   <= 1'b0;
    end else begin
      // a pending write always goes first
      if (!o_rd_busy && !i_wr_busy && !i_awvalid && i_arvalid) begin
        o_arready <= 1'b1;
        o_rd_busy <= 1'b1;
      end else begin
        o_arready <= 1'b0;
      end

      // one bubble cycle while the RAM fetches the next word
      fetch_q <= ar_hs || (r_hs && !beat_last);

      if (fetch_q) begin
        o_rvalid <= 1'b1;
      end else if (r_hs) begin
        o_rvalid <= 1'b0;
      end

      if (r_hs && beat_last) begin
        o_rd_busy <= 1'b0;
      end
    end
  end

  assign o_rd_idx = rd_addr.field.idx;

  // address is frozen during RVALID so the RAM output holds too
  always_comb begin
    o_r.data = i_rd_data;
    o_r.resp = burst_err ? axi_burst_pkg::SLVERR : axi_burst_pkg::OKAY;
    o_r.last = beat_last;
  end

  a_r_stable: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (o_rvalid && !i_rready) |=> (o_rvalid && $stable(o_r))
  ) else $error("R beat changed while stalled");

endmodule

//--- logic/write_channel.sv
`timescale 1ns/1ps

module write_channel (
  input  logic                         S_AXI_ACLK,
  input  logic                         S_AXI_ARESETN,
  input  axi_burst_pkg::axi_addr_req_t i_aw,
  input  logic                         i_awvalid,
  output logic                         o_awready,
  input  axi_burst_pkg::w_beat_t       i_w,
  input  logic                         i_wvalid,
  output logic                         o_wready,
  output axi_burst_pkg::axi_resp_e     o_bresp,
  output logic                         o_bvalid,
  input  logic                         i_bready,
  input  logic                         i_rd_busy,
  output logic                         o_wr_busy,
  output axi_burst_pkg::ram_wr_t       o_ram_wr
);
  axi_burst_pkg::axi_addr_u wr_addr;
  logic                     aw_hs;
  logic                     w_hs;
  logic                     b_hs;
  logic                     beat_last;
  logic                     burst_err;

  assign aw_hs = o_awready && i_awvalid;
  assign w_hs  = o_wready && i_wvalid;
  assign b_hs  = o_bvalid && i_bready;

  burst_addr_gen u_addr_gen (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .i_load        (aw_hs),
    .i_req         (i_aw),
    .i_advance     (w_hs),
    .o_addr        (wr_addr),
    .o_last        (beat_last),
    .o_err         (burst_err)
  );

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      o_awready <= 1'b0;
      o_wready  <= 1'b0;
      o_bvalid  <= 1'b0;
      o_wr_busy <= 1'b0;
    end else begin
      // claim the slave as soon as AW shows up and nobody is busy
      if (!o_wr_busy && !i_rd_busy && i_awvalid) begin
        o_awready <= 1'b1;
        o_wr_busy <= 1'b1;
      end else begin
        o_awready <= 1'b0;
      end

      if (aw_hs) begin
        o_wready <= 1'b1;
      end else if (w_hs && beat_last) begin
        o_wready <= 1'b0;
      end

      // response follows the final beat by one cycle
      if (w_hs && beat_last) begin
        o_bvalid <= 1'b1;
      end else if (b_hs) begin
        o_bvalid <= 1'b0;
      end

      if (b_hs) begin
        o_wr_busy <= 1'b0;
      end
    end
  end

  // held by the address generator until the next AW
  assign o_bresp = burst_err ? axi_burst_pkg::SLVERR : axi_burst_pkg::OKAY;

  // RAM takes the beat on the same edge it is accepted
  always_comb begin
    o_ram_wr.en   = w_hs && !burst_err;
    o_ram_wr.idx  = wr_addr.field.idx;
    o_ram_wr.data = i_w.data;
    o_ram_wr.strb = i_w.strb;
  end

  a_wready_needs_busy: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    o_wready |-> o_wr_busy
  ) else $error("WREADY high outside a write burst");

  a_wlast_matches_len: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    w_hs |-> (i_w.last == beat_last)
  ) else $error("WLAST disagrees with AWLEN beat count");

endmodule

//--- verif/tb_axi_burst_mem.sv
`timescale 1ns/1ps
`include "axi_burst_defines.svh"

module tb_axi_burst_mem;
  localparam int NUM_TESTS   = 7;
  localparam int CLK_NS      = 40;
  localparam int WATCHDOG_NS = NUM_TESTS * 17 * 20 * CLK_NS;
  localparam int MODEL_BYTES = `RAM_DEPTH * `AXI_STRB_W;

  logic                         S_AXI_ACLK;
  logic                         S_AXI_ARESETN;
  axi_burst_pkg::axi_addr_req_t s_axi_aw;
  logic                         s_axi_awvalid;
  logic                         s_axi_awready;
  axi_burst_pkg::w_beat_t       s_axi_w;
  logic                         s_axi_wvalid;
  logic                         s_axi_wready;
  axi_burst_pkg::axi_resp_e     s_axi_bresp;
  logic                         s_axi_bvalid;
  logic                         s_axi_bready;
  axi_burst_pkg::axi_addr_req_t s_axi_ar;
  logic                         s_axi_arvalid;
  logic                         s_axi_arready;
  axi_burst_pkg::r_beat_t       s_axi_r;
  logic                         s_axi_rvalid;
  logic                         s_axi_rready;

  // byte image of the buffer RAM
  logic [7:0] model_mem [MODEL_BYTES];
  int         errors;
  int         tests_ok;
  int         tests_bad;
  int         max_gap;
  time        b_done_time;
  time        ar_done_time;

  axi_burst_mem uut (
    .S_AXI_ACLK      (S_AXI_ACLK),
    .S_AXI_ARESETN   (S_AXI_ARESETN),
    .i_s_axi_aw      (s_axi_aw),
    .i_s_axi_awvalid (s_axi_awvalid),
    .o_s_axi_awready (s_axi_awready),
    .i_s_axi_w       (s_axi_w),
    .i_s_axi_wvalid  (s_axi_wvalid),
    .o_s_axi_wready  (s_axi_wready),
    .o_s_axi_bresp   (s_axi_bresp),
    .o_s_axi_bvalid  (s_axi_bvalid),
    .i_s_axi_bready  (s_axi_bready),
    .i_s_axi_ar      (s_axi_ar),
    .i_s_axi_arvalid (s_axi_arvalid),
    .o_s_axi_arready (s_axi_arready),
    .o_s_axi_r       (s_axi_r),
    .o_s_axi_rvalid  (s_axi_rvalid),
    .i_s_axi_rready  (s_axi_rready)
  );

  always #(CLK_NS / 2) S_AXI_ACLK = ~S_AXI_ACLK;

  // reserved type, or a wrap that is not 2, 4, 8 or 16 beats
  function automatic bit is_err_burst(input logic [7:0] len,
                                      input axi_burst_pkg::axi_burst_e burst);
    bit legal_wrap;
    case (int'(len) + 1)
      2, 4, 8, 16: legal_wrap = 1'b1;
      default:     legal_wrap = 1'b0;
    endcase
    return (burst == axi_burst_pkg::RESERVED) ||
           (burst == axi_burst_pkg::WRAP && !legal_wrap);
  endfunction

  // byte address of beat n
  function automatic logic [`AXI_ADDR_W-1:0] beat_addr(input logic [`AXI_ADDR_W-1:0] start,
                                                       input logic [7:0] len,
                                                       input axi_burst_pkg::axi_burst_e burst,
                                                       input int n);
    int aligned;
    int win;
    int base;
    aligned = int'(start) & ~3;
    win     = (int'(len) + 1) * 4;
    base    = aligned - (aligned % win);
    if (n == 0 || burst == axi_burst_pkg::FIXED || is_err_burst(len, burst)) begin
      return start;
    end
    if (burst == axi_burst_pkg::INCR) begin
      return `AXI_ADDR_W'(aligned + 4 * n);
    end
    return `AXI_ADDR_W'(base + ((aligned - base + 4 * n) % win));
  endfunction

  // upper address bits alias onto the same bytes
  function automatic logic [`AXI_DATA_W-1:0] model_word(input logic [`AXI_ADDR_W-1:0] addr);
    int i;
    i = (int'(addr) % MODEL_BYTES) & ~3;
    return {model_mem[i+3], model_mem[i+2], model_mem[i+1], model_mem[i]};
  endfunction

  task automatic model_store(input logic [`AXI_ADDR_W-1:0] addr,
                             input logic [`AXI_DATA_W-1:0] data,
                             input logic [`AXI_STRB_W-1:0] strb);
    int i;
    i = (int'(addr) % MODEL_BYTES) & ~3;
    for (int b = 0; b < `AXI_STRB_W; b++) begin
      if (strb[b]) begin
        model_mem[i+b] = data[8*b +: 8];
      end
    end
  endtask

  task automatic check_resp(input string what, input axi_burst_pkg::axi_resp_e got,
                            input axi_burst_pkg::axi_resp_e exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s response %s, expected %s", $time, what, got.name(),
               exp.name());
      errors++;
    end
  endtask

  task automatic check_rbeat(input string what, input axi_burst_pkg::r_beat_t got,
                             input axi_burst_pkg::r_beat_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s data %h resp %s last %b, expected data %h resp %s last %b",
               $time, what, got.data, got.resp.name(), got.last, exp.data, exp.resp.name(),
               exp.last);
      errors++;
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic do_write(input logic [`AXI_ADDR_W-1:0] addr, input logic [7:0] len,
                          input axi_burst_pkg::axi_burst_e burst, input bit rand_strb);
    logic [`AXI_DATA_W-1:0]   data_q [$];
    logic [`AXI_STRB_W-1:0]   strb_q [$];
    axi_burst_pkg::axi_resp_e exp_resp;
    bit                       err;
    err      = is_err_burst(len, burst);
    exp_resp = err ? axi_burst_pkg::SLVERR : axi_burst_pkg::OKAY;
    s_axi_aw.addr.byte_addr = addr;
    s_axi_aw.len            = len;
    s_axi_aw.burst          = burst;
    s_axi_awvalid           = 1'b1;
    while (!s_axi_awready) @(negedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    s_axi_awvalid = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      s_axi_wvalid = 1'b0;
      repeat ($urandom_range(0, max_gap)) @(negedge S_AXI_ACLK);
      data_q.push_back($urandom());
      strb_q.push_back(rand_strb ? `AXI_STRB_W'($urandom()) : {`AXI_STRB_W{1'b1}});
      s_axi_w.data = data_q[i];
      s_axi_w.strb = strb_q[i];
      s_axi_w.last = (i == int'(len));
      s_axi_wvalid = 1'b1;
      while (!s_axi_wready) @(negedge S_AXI_ACLK);
      @(negedge S_AXI_ACLK);
    end
    s_axi_wvalid = 1'b0;
    repeat ($urandom_range(0, max_gap)) @(negedge S_AXI_ACLK);
    s_axi_bready = 1'b1;
    while (!s_axi_bvalid) @(negedge S_AXI_ACLK);
    b_done_time = $time;
    check_resp("write", s_axi_bresp, exp_resp);
    @(negedge S_AXI_ACLK);
    s_axi_bready = 1'b0;
    // error bursts must not touch memory
    if (!err) begin
      for (int i = 0; i <= int'(len); i++) begin
        model_store(beat_addr(addr, len, burst, i), data_q[i], strb_q[i]);
      end
    end
  endtask

  task automatic do_read(input logic [`AXI_ADDR_W-1:0] addr, input logic [7:0] len,
                         input axi_burst_pkg::axi_burst_e burst);
    axi_burst_pkg::r_beat_t got;
    axi_burst_pkg::r_beat_t exp;
    bit                     err;
    err = is_err_burst(len, burst);
    s_axi_ar.addr.byte_addr = addr;
    s_axi_ar.len            = len;
    s_axi_ar.burst          = burst;
    s_axi_arvalid           = 1'b1;
    while (!s_axi_arready) @(negedge S_AXI_ACLK);
    ar_done_time = $time;
    @(negedge S_AXI_ACLK);
    s_axi_arvalid = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      s_axi_rready = 1'b0;
      repeat ($urandom_range(0, max_gap)) @(negedge S_AXI_ACLK);
      s_axi_rready = 1'b1;
      while (!s_axi_rvalid) @(negedge S_AXI_ACLK);
      got      = s_axi_r;
      exp.data = model_word(beat_addr(addr, len, burst, i));
      exp.resp = err ? axi_burst_pkg::SLVERR : axi_burst_pkg::OKAY;
      exp.last = (i == int'(len));
      check_rbeat($sformatf("read beat %0d", i), got, exp);
      @(negedge S_AXI_ACLK);
    end
    s_axi_rready = 1'b0;
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (errors == err_before) begin
      tests_ok++;
      $display("test %-14s ok", name);
    end else begin
      tests_bad++;
      $display("test %-14s failed with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic run_wrap_test();
    logic [`AXI_ADDR_W-1:0] a;
    logic [`AXI_ADDR_W-1:0] base;
    logic [7:0]             len;
    for (int k = 0; k < 4; k++) begin
      len    = 8'((2 << k) - 1);
      a      = `AXI_ADDR_W'($urandom());
      a[1:0] = 2'($urandom_range(1, 3));
      // start somewhere past the window base
      if (((a >> 2) & len) == 0) begin
        a = a + 12'd4;
      end
      base = a & ~`AXI_ADDR_W'((int'(len) + 1) * 4 - 1);
      do_write(a, len, axi_burst_pkg::WRAP, 1'b0);
      do_read(a, len, axi_burst_pkg::WRAP);
      do_read(base, len, axi_burst_pkg::INCR);
    end
  endtask

  task automatic run_backpressure_test();
    logic [`AXI_ADDR_W-1:0] wa;
    logic [`AXI_ADDR_W-1:0] ra;
    logic [7:0]             wlen;
    logic [7:0]             rlen;
    max_gap = 3;
    repeat (3) begin
      wa   = `AXI_ADDR_W'($urandom());
      ra   = $urandom_range(0, 1) ? wa : `AXI_ADDR_W'($urandom());
      wlen = 8'($urandom_range(0, 7));
      rlen = 8'($urandom_range(0, 7));
      fork
        do_write(wa, wlen, axi_burst_pkg::INCR, 1'b1);
        do_read(ra, rlen, axi_burst_pkg::INCR);
      join
      if (ar_done_time <= b_done_time) begin
        $display("ordering error: read address accepted at %0t ns before write response at %0t ns",
                 ar_done_time, b_done_time);
        errors++;
      end
    end
    max_gap = 0;
  endtask

  initial begin
    int                     err_before;
    logic [`AXI_ADDR_W-1:0] a;
    logic [7:0]             len;
    void'($urandom(46867));
    S_AXI_ACLK    = 1'b0;
    S_AXI_ARESETN = 1'b0;
    s_axi_aw      = '0;
    s_axi_awvalid = 1'b0;
    s_axi_w       = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_ar      = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    errors        = 0;
    tests_ok      = 0;
    tests_bad     = 0;
    max_gap       = 0;
    repeat (4) @(posedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    S_AXI_ARESETN = 1'b1;
    @(negedge S_AXI_ACLK);

    // fill every word so reads never see unknown data
    err_before = errors;
    do_write(12'h000, 8'd15, axi_burst_pkg::INCR, 1'b0);
    do_write(12'h040, 8'd15, axi_burst_pkg::INCR, 1'b0);
    finish_test("preload", err_before);

    err_before = errors;
    repeat (3) begin
      a   = `AXI_ADDR_W'($urandom());
      len = 8'($urandom_range(0, 15));
      do_write(a, len, axi_burst_pkg::INCR, 1'b0);
      do_read(a, len, axi_burst_pkg::INCR);
    end
    finish_test("incr", err_before);

    err_before = errors;
    run_wrap_test();
    finish_test("wrap", err_before);

    err_before = errors;
    a   = `AXI_ADDR_W'($urandom());
    len = 8'($urandom_range(1, 7));
    do_write(a, len, axi_burst_pkg::FIXED, 1'b0);
    do_read(a, 8'd3, axi_burst_pkg::FIXED);
    do_read(a, 8'd1, axi_burst_pkg::INCR);
    finish_test("fixed", err_before);

    err_before = errors;
    repeat (3) begin
      a   = `AXI_ADDR_W'($urandom());
      len = 8'($urandom_range(0, 7));
      do_write(a, len, axi_burst_pkg::INCR, 1'b1);
      do_read(a, len, axi_burst_pkg::INCR);
    end
    finish_test("strobes", err_before);

    err_before = errors;
    a   = `AXI_ADDR_W'($urandom());
    len = 8'($urandom_range(0, 3));
    do_write(a, len, axi_burst_pkg::RESERVED, 1'b0);
    do_read(a, len, axi_burst_pkg::RESERVED);
    do_write(a, 8'd2, axi_burst_pkg::WRAP, 1'b0);
    do_read(a, 8'd2, axi_burst_pkg::WRAP);
    do_read(a, 8'd3, axi_burst_pkg::INCR);
    finish_test("errors", err_before);

    err_before = errors;
    run_backpressure_test();
    finish_test("backpressure", err_before);

    $display("summary: %0d tests ok, %0d tests failed", tests_ok, tests_bad);
    if (tests_bad == 0 && errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // budget of 17 beats at 20 cycles each per test
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule
